/* Bender.yml */
package:
  name: alu_subsystem

sources:
  - source/alu_pkg.sv
  - source/alu.sv
  - source/register_file.sv
  - source/write_arbiter.sv
  - source/execute_unit.sv
  - source/alu_subsystem.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/alu_subsystem_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire  [alu_pkg::data_width-1:0]    operand_a,
	input  wire  [alu_pkg::data_width-1:0]    operand_b,
	input  wire  [alu_pkg::data_width-1:0]    immediate,
	input  wire  [alu_pkg::control_width-1:0] control,
	input  wire                               alu_source, // high selects immediate
	output logic [alu_pkg::data_width-1:0]    result,
	output logic                              z,
	output logic                              v,
	output logic                              c,
	output logic                              n,
	output logic                              write_enable
);
	import alu_pkg::*;

	logic [data_width-1:0] operand1;
	logic [data_width-1:0] twos_comp; // negated operand1 for sub flags
	logic a_msb;
	logic b_msb;
	logic t_msb;

	assign operand1  = alu_source ? immediate : operand_b;
	assign twos_comp = ~operand1 + data_width'(1);
	assign a_msb     = operand_a[data_width-1];
	assign b_msb     = operand1[data_width-1];
	assign t_msb     = twos_comp[data_width-1];

	always_comb begin
		result       = '0;
		v            = 1'b0;
		c            = 1'b0;
		write_enable = 1'b1;
		case (control)
			op_add: begin
				result = operand_a + operand1;
				v = (a_msb ~^ b_msb) & (a_msb ^ result[data_width-1]); // sign flipped
				c = (a_msb & b_msb) | ((a_msb | b_msb) & ~result[data_width-1]);
			end
			op_sub: begin
				result = operand_a - operand1;
				v = (a_msb & t_msb & ~result[data_width-1])
					| (~a_msb & ~t_msb & result[data_width-1]);
				c = (a_msb & t_msb) | ((a_msb | t_msb) & ~result[data_width-1])
					| ((operand_a == '0) & (operand1 == '0)); // 0 - 0 counts as carry
			end
			op_and: begin
				result = operand_a & operand1;
			end
			op_or: begin
				result = operand_a | operand1;
			end
			op_xor: begin
				result = operand_a ^ operand1;
			end
			op_slt: begin
				result = (operand_a < operand1) ? data_width'(1) : '0;
			end
			op_sll: begin
				result = operand_a << operand1; // amounts of 32 and up give zero
			end
			default: begin
				write_enable = 1'b0; // nop and unknown codes
			end
		endcase
		z = write_enable & (result == '0); // nop keeps all flags low
		n = result[data_width-1];
	end

endmodule

`default_nettype wire

/* source/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	localparam int data_width     = 32; // operand and register word
	localparam int reg_addr_width = 5;
	localparam int reg_count      = 32;
	localparam int control_width  = 6;

	// function codes
	localparam logic [control_width-1:0] op_nop = 6'd0;
	localparam logic [control_width-1:0] op_add = 6'd32;
	localparam logic [control_width-1:0] op_sub = 6'd34;
	localparam logic [control_width-1:0] op_and = 6'd36;
	localparam logic [control_width-1:0] op_or  = 6'd37;
	localparam logic [control_width-1:0] op_xor = 6'd38;
	localparam logic [control_width-1:0] op_slt = 6'd42; // unsigned compare
	localparam logic [control_width-1:0] op_sll = 6'd4;

endpackage

`default_nettype wire

/* source/alu_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_subsystem (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                issue,
	input  wire  [alu_pkg::control_width-1:0]  control,
	input  wire  [alu_pkg::reg_addr_width-1:0] rs,
	input  wire  [alu_pkg::reg_addr_width-1:0] rt,
	input  wire  [alu_pkg::reg_addr_width-1:0] rd,
	input  wire  [alu_pkg::data_width-1:0]     immediate,
	input  wire                                alu_source,
	input  wire                                host_we,
	input  wire  [alu_pkg::reg_addr_width-1:0] host_waddr,
	input  wire  [alu_pkg::data_width-1:0]     host_wdata,
	output wire                                host_write_busy,
	input  wire                                host_re,
	input  wire  [alu_pkg::reg_addr_width-1:0] host_raddr,
	output wire  [alu_pkg::data_width-1:0]     host_rdata,
	output wire                                host_rvalid,
	output wire                                done,
	output wire  [alu_pkg::data_width-1:0]     result,
	output wire                                z,
	output wire                                v,
	output wire                                c,
	output wire                                n
);
	import alu_pkg::*;

	wire                      exec_we;
	wire [reg_addr_width-1:0] exec_waddr;
	wire [data_width-1:0]     exec_wdata;
	wire                      rf_we;
	wire [reg_addr_width-1:0] rf_waddr;
	wire [data_width-1:0]     rf_wdata;
	wire [reg_addr_width-1:0] raddr0;
	wire [reg_addr_width-1:0] raddr1;
	wire [data_width-1:0]     rdata0;
	wire [data_width-1:0]     rdata1;

	execute_unit i_execute_unit (
		.clk        (clk),
		.reset      (reset),
		.issue      (issue),
		.control    (control),
		.rs         (rs),
		.rt         (rt),
		.rd         (rd),
		.immediate  (immediate),
		.alu_source (alu_source),
		.raddr0     (raddr0),
		.raddr1     (raddr1),
		.rdata0     (rdata0),
		.rdata1     (rdata1),
		.exec_we    (exec_we),
		.exec_waddr (exec_waddr),
		.exec_wdata (exec_wdata),
		.done       (done),
		.result     (result),
		.z          (z),
		.v          (v),
		.c          (c),
		.n          (n)
	);

	write_arbiter i_write_arbiter (
		.clk             (clk),
		.reset           (reset),
		.exec_we         (exec_we),
		.exec_waddr      (exec_waddr),
		.exec_wdata      (exec_wdata),
		.host_we         (host_we),
		.host_waddr      (host_waddr),
		.host_wdata      (host_wdata),
		.host_write_busy (host_write_busy),
		.rf_we           (rf_we),
		.rf_waddr        (rf_waddr),
		.rf_wdata        (rf_wdata)
	);

	register_file i_register_file (
		.clk         (clk),
		.reset       (reset),
		.raddr0      (raddr0),
		.raddr1      (raddr1),
		.host_raddr  (host_raddr),
		.rdata0      (rdata0),
		.rdata1      (rdata1),
		.host_re     (host_re),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.we          (rf_we),
		.waddr       (rf_waddr),
		.wdata       (rf_wdata)
	);

endmodule

`default_nettype wire

/* source/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                issue,
	input  wire  [alu_pkg::control_width-1:0]  control,
	input  wire  [alu_pkg::reg_addr_width-1:0] rs,
	input  wire  [alu_pkg::reg_addr_width-1:0] rt,
	input  wire  [alu_pkg::reg_addr_width-1:0] rd,
	input  wire  [alu_pkg::data_width-1:0]     immediate,
	input  wire                                alu_source,
	output logic [alu_pkg::reg_addr_width-1:0] raddr0,
	output logic [alu_pkg::reg_addr_width-1:0] raddr1,
	input  wire  [alu_pkg::data_width-1:0]     rdata0,
	input  wire  [alu_pkg::data_width-1:0]     rdata1,
	output logic                               exec_we,
	output logic [alu_pkg::reg_addr_width-1:0] exec_waddr,
	output logic [alu_pkg::data_width-1:0]     exec_wdata,
	output logic                               done,
	output logic [alu_pkg::data_width-1:0]     result,
	output logic                               z,
	output logic                               v,
	output logic                               c,
	output logic                               n
);
	import alu_pkg::*;

	logic                      stage_valid;
	logic [control_width-1:0]  stage_control;
	logic [reg_addr_width-1:0] stage_rs;
	logic [reg_addr_width-1:0] stage_rt;
	logic [reg_addr_width-1:0] stage_rd;
	logic [data_width-1:0]     stage_imm;
	logic                      stage_src;
	logic [data_width-1:0]     alu_result;
	logic                      alu_z;
	logic                      alu_v;
	logic                      alu_c;
	logic                      alu_n;
	logic                      alu_we;

	always_ff @(posedge clk) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else begin
			stage_valid <= issue;
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			stage_control <= control;
			stage_rs      <= rs;
			stage_rt      <= rt;
			stage_rd      <= rd;
			stage_imm     <= immediate;
			stage_src     <= alu_source;
		end
	end

	assign raddr0 = stage_rs;
	assign raddr1 = stage_rt;

	alu i_alu (
		.operand_a    (rdata0),
		.operand_b    (rdata1),
		.immediate    (stage_imm),
		.control      (stage_control),
		.alu_source   (stage_src),
		.result       (alu_result),
		.z            (alu_z),
		.v            (alu_v),
		.c            (alu_c),
		.n            (alu_n),
		.write_enable (alu_we)
	);

	// writeback commits at the end of the execute cycle
	assign exec_we    = stage_valid & alu_we;
	assign exec_waddr = stage_rd;
	assign exec_wdata = alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			done <= 1'b0;
			z    <= 1'b0;
			v    <= 1'b0;
			c    <= 1'b0;
			n    <= 1'b0;
		end else begin
			done <= stage_valid; // one pulse per instruction
			if (stage_valid) begin
				z <= alu_z;
				v <= alu_v;
				c <= alu_c;
				n <= alu_n;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (stage_valid) begin
			result <= alu_result;
		end
	end

endmodule

`default_nettype wire

/* source/register_file.sv */
`timescale 1ns/1ps
`default_nettype none

module register_file (
	input  wire                                clk,
	input  wire                                reset,
	input  wire  [alu_pkg::reg_addr_width-1:0] raddr0,
	input  wire  [alu_pkg::reg_addr_width-1:0] raddr1,
	input  wire  [alu_pkg::reg_addr_width-1:0] host_raddr,
	output logic [alu_pkg::data_width-1:0]     rdata0,
	output logic [alu_pkg::data_width-1:0]     rdata1,
	input  wire                                host_re,
	output logic [alu_pkg::data_width-1:0]     host_rdata,
	output logic                               host_rvalid,
	input  wire                                we,
	input  wire  [alu_pkg::reg_addr_width-1:0] waddr,
	input  wire  [alu_pkg::data_width-1:0]     wdata
);
	import alu_pkg::*;

	logic [data_width-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < reg_count; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (waddr != '0)) begin // register 0 stays zero
			regs[waddr] <= wdata;
		end
	end

	// execute reads, same cycle
	assign rdata0 = regs[raddr0];
	assign rdata1 = regs[raddr1];

	always_ff @(posedge clk) begin
		if (reset) begin
			host_rvalid <= 1'b0;
		end else begin
			host_rvalid <= host_re;
		end
	end

	always_ff @(posedge clk) begin
		if (host_re) begin
			host_rdata <= regs[host_raddr]; // old contents if written this edge
		end
	end

endmodule

`default_nettype wire

/* source/write_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                exec_we,
	input  wire  [alu_pkg::reg_addr_width-1:0] exec_waddr,
	input  wire  [alu_pkg::data_width-1:0]     exec_wdata,
	input  wire                                host_we,
	input  wire  [alu_pkg::reg_addr_width-1:0] host_waddr,
	input  wire  [alu_pkg::data_width-1:0]     host_wdata,
	output logic                               host_write_busy,
	output logic                               rf_we,
	output logic [alu_pkg::reg_addr_width-1:0] rf_waddr,
	output logic [alu_pkg::data_width-1:0]     rf_wdata
);
	import alu_pkg::*;

	logic                      slot_valid;
	logic [reg_addr_width-1:0] slot_addr;
	logic [data_width-1:0]     slot_data;
	logic                      park; // host write cannot go out this cycle

	assign park = host_we & (exec_we | slot_valid);

	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (park) begin
			slot_valid <= 1'b1;
		end else if (!exec_we) begin
			slot_valid <= 1'b0; // slot drained this cycle
		end
	end

	always_ff @(posedge clk) begin
		if (park) begin
			slot_addr <= host_waddr;
			slot_data <= host_wdata;
		end
	end

	assign host_write_busy = slot_valid;

	// execute first, then parked write, then direct host write
	always_comb begin
		rf_we = exec_we | slot_valid | host_we;
		if (exec_we) begin
			rf_waddr = exec_waddr;
			rf_wdata = exec_wdata;
		end else if (slot_valid) begin
			rf_waddr = slot_addr;
			rf_wdata = slot_data;
		end else begin
			rf_waddr = host_waddr;
			rf_wdata = host_wdata;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+test
source/alu_pkg.sv
source/alu.sv
source/register_file.sv
source/write_arbiter.sv
source/execute_unit.sv
source/alu_subsystem.sv
test/alu_subsystem_tb.sv

/* test/alu_ref_model.svh */
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// known codes other than nop write their destination
function automatic logic writes_back(input logic [control_width-1:0] code);
	case (code)
		op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll: return 1'b1;
		default: return 1'b0;
	endcase
endfunction

function automatic logic [data_width-1:0] alu_value(
	input logic [control_width-1:0] code,
	input logic [data_width-1:0]    a,
	input logic [data_width-1:0]    b
);
	case (code)
		op_add: return a + b;
		op_sub: return a + ~b + data_width'(1); // add the negated operand
		op_and: return a & b;
		op_or:  return a | b;
		op_xor: return a ^ b;
		op_slt: return (a < b) ? data_width'(1) : '0; // unsigned
		op_sll: return (b >= data_width) ? '0 : a << b[4:0];
		default: return '0;
	endcase
endfunction

// returns {z, v, c, n}
function automatic logic [3:0] flag_bits(
	input logic [control_width-1:0] code,
	input logic [data_width-1:0]    a,
	input logic [data_width-1:0]    b
);
	logic [data_width:0]   sum; // top bit is the carry out
	logic [data_width-1:0] addend;
	logic [data_width-1:0] res;
	logic                  ovf;
	logic                  carry;
	if (!writes_back(code)) begin
		return 4'b0;
	end
	res   = alu_value(code, a, b);
	ovf   = 1'b0;
	carry = 1'b0;
	if (code == op_add || code == op_sub) begin
		addend = (code == op_sub) ? (~b + data_width'(1)) : b;
		sum    = {1'b0, a} + {1'b0, addend};
		carry  = sum[data_width];
		ovf    = (a[data_width-1] == addend[data_width-1]) && (res[data_width-1] != a[data_width-1]);
		if (code == op_sub && a == '0 && b == '0) begin
			carry = 1'b1;
		end
	end
	return {res == '0, ovf, carry, res[data_width-1]};
endfunction

`endif

/* test/alu_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_subsystem_tb;
	import alu_pkg::*;

	`include "alu_ref_model.svh"

	localparam int num_codes    = 10;
	localparam int chain_length = 24;
	localparam logic [control_width-1:0] codes [num_codes] = '{
		op_nop, op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sll, 6'd1, 6'd63
	};
	// reset, then tests 1 to 6 and the final drain
	localparam int stim_cycles = 4 + 47 + (num_codes * 49 + 9) + (num_codes * 4 + 3)
		+ (chain_length + 36) + 41 + 41 + 3;
	localparam int timeout_cycles = 2 * stim_cycles + 100;

	logic                      clk = 1'b0;
	logic                      reset;
	logic                      issue;
	logic [control_width-1:0]  control;
	logic [reg_addr_width-1:0] rs;
	logic [reg_addr_width-1:0] rt;
	logic [reg_addr_width-1:0] rd;
	logic [data_width-1:0]     immediate;
	logic                      alu_source;
	logic                      host_we;
	logic [reg_addr_width-1:0] host_waddr;
	logic [data_width-1:0]     host_wdata;
	wire                       host_write_busy;
	logic                      host_re;
	logic [reg_addr_width-1:0] host_raddr;
	wire  [data_width-1:0]     host_rdata;
	wire                       host_rvalid;
	wire                       done;
	wire  [data_width-1:0]     result;
	wire                       z;
	wire                       v;
	wire                       c;
	wire                       n;

	logic [data_width-1:0]     shadow [reg_count];
	logic [data_width-1:0]     rd_expect;  // value the pending host read must return
	logic [data_width+3:0]     exp_word;   // {result, z, v, c, n}
	logic                      busy_expect;
	integer                    seed;
	int                        error_count = 0;
	int                        errors_at_start = 0;
	int                        test_count = 0;
	int                        cycle_count = 0;

	alu_subsystem i_dut (
		.clk             (clk),
		.reset           (reset),
		.issue           (issue),
		.control         (control),
		.rs              (rs),
		.rt              (rt),
		.rd              (rd),
		.immediate       (immediate),
		.alu_source      (alu_source),
		.host_we         (host_we),
		.host_waddr      (host_waddr),
		.host_wdata      (host_wdata),
		.host_write_busy (host_write_busy),
		.host_re         (host_re),
		.host_raddr      (host_raddr),
		.host_rdata      (host_rdata),
		.host_rvalid     (host_rvalid),
		.done            (done),
		.result          (result),
		.z               (z),
		.v               (v),
		.c               (c),
		.n               (n)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Run stopped at %0t: cycle limit of %0d reached", $time, timeout_cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	done_follows_issue: assert property (@(posedge clk) disable iff (reset)
		done == $past(issue, 2))
		else begin
			$display("Error at %0t: done did not pulse one cycle after the issue edge", $time);
			error_count++;
		end

	result_matches_model: assert property (@(posedge clk) disable iff (reset)
		done |-> {result, z, v, c, n} == $past(exp_word, 2))
		else begin
			$display("Mismatch at %0t: execute result or flags differ from the model", $time);
			error_count++;
		end

	rvalid_follows_re: assert property (@(posedge clk) disable iff (reset)
		host_rvalid == $past(host_re))
		else begin
			$display("Error at %0t: host_rvalid did not follow host_re by one cycle", $time);
			error_count++;
		end

	read_matches_shadow: assert property (@(posedge clk) disable iff (reset)
		host_rvalid |-> host_rdata == $past(rd_expect))
		else begin
			$display("Mismatch at %0t: host read data differs from the shadow copy", $time);
			error_count++;
		end

	busy_on_collision: assert property (@(posedge clk) disable iff (reset)
		host_write_busy == $past(busy_expect))
		else begin
			$display("Mismatch at %0t: host_write_busy level is wrong", $time);
			error_count++;
		end

	reset_clears_outputs: assert property (@(posedge clk)
		reset |=> !done && !host_rvalid && !host_write_busy && {z, v, c, n} == 4'b0)
		else begin
			$display("Error at %0t: outputs not cleared by reset", $time);
			error_count++;
		end

	function automatic logic [data_width-1:0] rand_word();
		return $random(seed);
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) @(posedge clk);
	endtask

	task automatic apply_reset();
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < reg_count; i++) begin
			shadow[i] = '0;
		end
	endtask

	task automatic write_register(
		input logic [reg_addr_width-1:0] addr,
		input logic [data_width-1:0]     data,
		input logic                      collide // execute writes on the same edge
	);
		host_we     <= 1'b1;
		host_waddr  <= addr;
		host_wdata  <= data;
		busy_expect <= collide;
		@(posedge clk);
		host_we     <= 1'b0;
		busy_expect <= 1'b0;
		if (addr != '0) begin
			shadow[addr] = data;
		end
	endtask

	task automatic read_all();
		for (int i = 0; i < reg_count; i++) begin
			host_re    <= 1'b1;
			host_raddr <= reg_addr_width'(i);
			rd_expect  <= shadow[i];
			@(posedge clk);
			host_re    <= 1'b0;
		end
		idle(2); // last check lands here
	endtask

	task automatic execute(
		input logic [control_width-1:0]  code,
		input logic [reg_addr_width-1:0] src_a,
		input logic [reg_addr_width-1:0] src_b,
		input logic [reg_addr_width-1:0] dest,
		input logic [data_width-1:0]     imm,
		input logic                      use_imm
	);
		logic [data_width-1:0] a;
		logic [data_width-1:0] b;
		a = shadow[src_a];
		b = use_imm ? imm : shadow[src_b];
		issue      <= 1'b1;
		control    <= code;
		rs         <= src_a;
		rt         <= src_b;
		rd         <= dest;
		immediate  <= imm;
		alu_source <= use_imm;
		exp_word   <= {alu_value(code, a, b), flag_bits(code, a, b)};
		@(posedge clk);
		issue <= 1'b0;
		if (writes_back(code) && dest != '0) begin
			shadow[dest] = alu_value(code, a, b); // written before the next read
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %0d errors", test_count, name, error_count - errors_at_start);
		errors_at_start = error_count;
	endtask

	initial begin
		logic [data_width-1:0]     rnd;
		logic [data_width-1:0]     imm;
		logic [reg_addr_width-1:0] prev;
		logic [reg_addr_width-1:0] next;
		seed        = 32'h73d2_5634;
		reset       = 1'b1;
		issue       = 1'b0;
		control     = op_nop;
		rs          = '0;
		rt          = '0;
		rd          = '0;
		immediate   = '0;
		alu_source  = 1'b0;
		host_we     = 1'b0;
		host_waddr  = '0;
		host_wdata  = '0;
		host_re     = 1'b0;
		host_raddr  = '0;
		rd_expect   = '0;
		exp_word    = '0;
		busy_expect = 1'b0;
		apply_reset();

		for (int i = 0; i < 12; i++) begin
			rnd = rand_word();
			write_register(rnd[4:0], rand_word(), 1'b0);
		end
		write_register(5'd0, 32'hffff_ffff, 1'b0); // must stay zero
		read_all();
		end_test("host write and read");

		write_register(5'd1, 32'h8000_0000, 1'b0);
		write_register(5'd2, 32'hffff_ffff, 1'b0);
		write_register(5'd3, 32'h7fff_ffff, 1'b0);
		write_register(5'd4, 32'd32, 1'b0); // shift amount at the limit
		rnd = rand_word();
		write_register(5'd5, {27'b0, rnd[4:0]}, 1'b0);
		write_register(5'd6, rand_word(), 1'b0);
		for (int i = 0; i < num_codes; i++) begin
			for (int s = 0; s < 7; s++) begin
				for (int t = 0; t < 7; t++) begin
					execute(codes[i], reg_addr_width'(s), reg_addr_width'(t), 5'd31,
						rand_word(), 1'b0);
				end
			end
		end
		idle(3);
		end_test("all function codes");

		for (int i = 0; i < num_codes; i++) begin
			for (int j = 0; j < 4; j++) begin
				rnd = rand_word();
				case (j)
					0: imm = '0;
					1: imm = 32'h8000_0000;
					2: imm = 32'd33;
					default: imm = rand_word();
				endcase
				execute(codes[i], {2'b0, rnd[2:0]}, rnd[7:3], 5'd30, imm, 1'b1);
			end
		end
		idle(3);
		end_test("immediate select");

		prev = 5'd8;
		for (int k = 0; k < chain_length; k++) begin
			rnd  = rand_word();
			next = {2'b01, rnd[2:0]}; // destinations 8 to 15
			imm  = rand_word();
			execute(codes[rnd[31:8] % num_codes], prev, {1'b0, rnd[6:3]}, next, imm, rnd[7]);
			prev = next;
		end
		idle(2);
		read_all();
		end_test("writeback and dependency");

		execute(op_add, 5'd1, 5'd3, 5'd20, '0, 1'b0);
		write_register(5'd20, rand_word(), 1'b1); // same address, host lands last
		execute(op_or, 5'd2, 5'd6, 5'd21, '0, 1'b0);
		write_register(5'd22, rand_word(), 1'b1);
		idle(3);
		read_all();
		end_test("write collision");

		write_register(5'd12, 32'h1234_5678, 1'b0);
		execute(op_sub, 5'd0, 5'd0, 5'd12, '0, 1'b0); // sets z and c
		host_we     <= 1'b1; // parks behind the sub writeback
		host_waddr  <= 5'd12;
		host_wdata  <= rand_word();
		busy_expect <= 1'b1;
		execute(op_add, 5'd1, 5'd3, 5'd13, '0, 1'b0);
		host_we     <= 1'b0;
		busy_expect <= 1'b0;
		apply_reset(); // lands with done due and the slot held by a writeback
		read_all();
		end_test("reset");

		idle(3);
		$display("%0d tests run, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
